//--- src/exec_pkg.sv
package exec_pkg;

    // ---------------------------------------------------------------------
    // Widths
    // ---------------------------------------------------------------------
    localparam int data_w   = 32;
    localparam int reg_w    = 4;
    localparam int num_regs = 16;   // Register 0 always reads as zero.
    localparam int shamt_w  = 5;

    // ---------------------------------------------------------------------
    // Instruction opcodes, in the classic teaching encoding
    // ---------------------------------------------------------------------
    typedef enum logic [4:0] {
        op_ld     = 5'd0,
        op_ldi    = 5'd1,
        op_st     = 5'd2,
        op_add    = 5'd3,
        op_sub    = 5'd4,
        op_and    = 5'd5,
        op_or     = 5'd6,
        op_shr    = 5'd7,
        op_shra   = 5'd8,
        op_shl    = 5'd9,
        op_ror    = 5'd10,
        op_rol    = 5'd11,
        op_addi   = 5'd12,
        op_andi   = 5'd13,
        op_ori    = 5'd14,
        op_mul    = 5'd15,
        op_div    = 5'd16,
        op_neg    = 5'd17,
        op_not    = 5'd18,
        op_branch = 5'd19,
        op_jr     = 5'd20,
        op_jal    = 5'd21,
        op_in     = 5'd22,
        op_out    = 5'd23,
        op_mfhi   = 5'd24,
        op_mflo   = 5'd25,
        op_nop    = 5'd26,
        op_halt   = 5'd27
    } opcode_t;

    // Four steps per instruction after the idle state.
    typedef enum logic [2:0] {
        st_idle,
        st_inc,
        st_oper,
        st_exec,
        st_wb
    } seq_state_t;

endpackage

//--- src/alu_if.sv
`timescale 1ns/1ns

interface alu_if;
    import exec_pkg::*;

    opcode_t            opcode;
    logic [data_w-1:0]  y;
    logic [data_w-1:0]  b;
    logic               inc_pc;     // Selects the PC increment path over the opcode.
    logic               br_flag;
    logic [data_w-1:0]  hi;
    logic [data_w-1:0]  lo;

    modport ctrl (
        output opcode, y, b, inc_pc, br_flag,
        input  hi, lo
    );

    modport unit (
        input  opcode, y, b, inc_pc, br_flag,
        output hi, lo
    );

endinterface

//--- src/shift_unit.sv
`timescale 1ns/1ns

module shift_unit (
    input  logic [exec_pkg::data_w-1:0]  y,
    input  logic [exec_pkg::shamt_w-1:0] amount,
    output logic [exec_pkg::data_w-1:0]  shr_out,
    output logic [exec_pkg::data_w-1:0]  shra_out,
    output logic [exec_pkg::data_w-1:0]  shl_out,
    output logic [exec_pkg::data_w-1:0]  ror_out,
    output logic [exec_pkg::data_w-1:0]  rol_out
);
    import exec_pkg::*;

    logic [2*data_w-1:0] doubled;
    logic [2*data_w-1:0] ror_wide;
    logic [2*data_w-1:0] rol_wide;

    // Plain shifts fill with zeros from the vacated side.
    assign shr_out = y >> amount;
    assign shl_out = y << amount;

    // Arithmetic shift keeps the sign bit.
    assign shra_out = $signed(y) >>> amount;

    // ---------------------------------------------------------------------
    // Rotations
    // ---------------------------------------------------------------------
    // Shifting two copies side by side brings the wrapped bits into
    // the window, so an amount of zero needs no special case.
    assign doubled  = {y, y};
    assign ror_wide = doubled >> amount;
    assign rol_wide = doubled << amount;

    assign ror_out = ror_wide[data_w-1:0];         // Low copy holds the right rotation.
    assign rol_out = rol_wide[2*data_w-1:data_w];  // High copy holds the left rotation.

endmodule

//--- src/mul_div_unit.sv
`timescale 1ns/1ns

module mul_div_unit (
    input  logic [exec_pkg::data_w-1:0] y,
    input  logic [exec_pkg::data_w-1:0] b,
    output logic [exec_pkg::data_w-1:0] mul_hi,
    output logic [exec_pkg::data_w-1:0] mul_lo,
    output logic [exec_pkg::data_w-1:0] div_quot,
    output logic [exec_pkg::data_w-1:0] div_rem
);
    import exec_pkg::*;

    logic signed [data_w-1:0]   ys;
    logic signed [data_w-1:0]   bs;
    logic signed [2*data_w-1:0] product;
    logic                       div_zero;
    logic                       div_ovf;

    assign ys = y;
    assign bs = b;

    // ---------------------------------------------------------------------
    // Multiply
    // ---------------------------------------------------------------------
    // Both operands are signed, so they are sign extended to the full
    // product width before the multiply.
    assign product = ys * bs;
    assign mul_hi  = product[2*data_w-1:data_w];
    assign mul_lo  = product[data_w-1:0];

    // ---------------------------------------------------------------------
    // Divide
    // ---------------------------------------------------------------------
    assign div_zero = (b == '0);

    // The most negative value over minus one does not fit in 32 bits.
    assign div_ovf = (y == {1'b1, {(data_w-1){1'b0}}}) && (b == '1);

    always_comb begin
        if (div_zero) begin
            div_quot = '0;
            div_rem  = y;           // The dividend passes through untouched.
        end else if (div_ovf) begin
            div_quot = y;           // Wraps back to the most negative value.
            div_rem  = '0;
        end else begin
            // Truncates toward zero, remainder carries the dividend's sign.
            div_quot = ys / bs;
            div_rem  = ys % bs;
        end
    end

endmodule

//--- src/alu.sv
`timescale 1ns/1ns

module alu (
    alu_if.unit bus
);
    import exec_pkg::*;

    logic [data_w-1:0] add_out;
    logic [data_w-1:0] sub_out;
    logic [data_w-1:0] shr_out;
    logic [data_w-1:0] shra_out;
    logic [data_w-1:0] shl_out;
    logic [data_w-1:0] ror_out;
    logic [data_w-1:0] rol_out;
    logic [data_w-1:0] mul_hi;
    logic [data_w-1:0] mul_lo;
    logic [data_w-1:0] div_quot;
    logic [data_w-1:0] div_rem;

    assign add_out = bus.y + bus.b;
    assign sub_out = bus.y - bus.b;

    shift_unit u_shift (
        .y        (bus.y),
        .amount   (bus.b[shamt_w-1:0]),     // Only the low bits of B count.
        .shr_out  (shr_out),
        .shra_out (shra_out),
        .shl_out  (shl_out),
        .ror_out  (ror_out),
        .rol_out  (rol_out)
    );

    mul_div_unit u_mul_div (
        .y        (bus.y),
        .b        (bus.b),
        .mul_hi   (mul_hi),
        .mul_lo   (mul_lo),
        .div_quot (div_quot),
        .div_rem  (div_rem)
    );

    // ---------------------------------------------------------------------
    // Result select
    // ---------------------------------------------------------------------
    always_comb begin
        bus.hi = '0;    // Only mul and div produce an upper word.
        bus.lo = '0;
        if (bus.inc_pc) begin
            bus.lo = bus.b + 32'd1;
        end else begin
            case (bus.opcode)
                op_add, op_ld, op_ldi, op_st, op_addi: bus.lo = add_out;
                op_sub:          bus.lo = sub_out;
                op_and, op_andi: bus.lo = bus.y & bus.b;
                op_or, op_ori:   bus.lo = bus.y | bus.b;
                op_neg:          bus.lo = -bus.b;
                op_not:          bus.lo = ~bus.b;
                op_shr:          bus.lo = shr_out;
                op_shra:         bus.lo = shra_out;
                op_shl:          bus.lo = shl_out;
                op_ror:          bus.lo = ror_out;
                op_rol:          bus.lo = rol_out;
                op_mul: begin
                    bus.hi = mul_hi;
                    bus.lo = mul_lo;
                end
                op_div: begin
                    bus.hi = div_rem;
                    bus.lo = div_quot;
                end
                op_branch: begin
                    // A taken branch adds the offset to the incremented PC.
                    bus.lo = bus.br_flag ? add_out : bus.y;
                end
                default: begin
                    bus.hi = '0;
                    bus.lo = '0;
                end
            endcase
        end
    end

endmodule

//--- src/exec_ctrl.sv
`timescale 1ns/1ns

module exec_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  exec_pkg::opcode_t            opcode,
    input  logic [exec_pkg::reg_w-1:0]   rd,
    input  logic [exec_pkg::reg_w-1:0]   ra,
    input  logic [exec_pkg::reg_w-1:0]   rb,
    input  logic [exec_pkg::data_w-1:0]  imm,
    input  logic [exec_pkg::data_w-1:0]  pc,
    input  logic                         br_flag,
    alu_if.ctrl                          alu,
    output logic                         busy,
    output logic                         done,
    output logic                         halted,
    output logic                         wb_en,
    output logic [exec_pkg::reg_w-1:0]   wb_addr,
    output logic [exec_pkg::data_w-1:0]  wb_data,
    output logic [exec_pkg::data_w-1:0]  hi,
    output logic [exec_pkg::data_w-1:0]  lo,
    output logic [exec_pkg::data_w-1:0]  pc_next
);
    import exec_pkg::*;

    seq_state_t        state;
    opcode_t           op_q;
    logic [reg_w-1:0]  rd_q, ra_q, rb_q;
    logic [data_w-1:0] imm_q, pc_q;
    logic              br_q;
    logic [data_w-1:0] regs [num_regs];
    logic [data_w-1:0] pc_plus1, y_q, b_q, z_hi, z_lo;
    logic [data_w-1:0] hi_q, lo_q, pc_next_q;
    logic [data_w-1:0] rf_a, rf_b, result, target;
    logic              accept, writes_reg, is_imm, loads_hilo;

    assign accept = start && (state == st_idle) && !halted;
    assign rf_a   = (ra_q == '0) ? '0 : regs[ra_q];
    assign rf_b   = (rb_q == '0) ? '0 : regs[rb_q];

    // ---------------------------------------------------------------------
    // Sequencer
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_inc;
                    end
                end
                st_inc:  state <= st_oper;
                st_oper: state <= st_exec;
                st_exec: state <= st_wb;
                default: state <= st_idle;  // Write-back always returns to idle.
            endcase
        end
    end

    // Instruction fields, operands and ALU results.
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q  <= opcode;
            rd_q  <= rd;
            ra_q  <= ra;
            rb_q  <= rb;
            imm_q <= imm;
            pc_q  <= pc;
            br_q  <= br_flag;
        end
        if (state == st_inc) begin
            pc_plus1 <= alu.lo;
        end
        if (state == st_oper) begin
            y_q <= (op_q == op_branch) ? pc_plus1 : rf_a;
            b_q <= (is_imm || op_q == op_branch) ? imm_q : rf_b;
        end
        if (state == st_exec) begin
            z_hi <= alu.hi;
            z_lo <= alu.lo;
        end
    end

    assign alu.opcode  = op_q;
    assign alu.inc_pc  = (state == st_inc);
    assign alu.y       = y_q;
    assign alu.b       = (state == st_inc) ? pc_q : b_q;   // PC rides on B for the increment.
    assign alu.br_flag = br_q;

    // ---------------------------------------------------------------------
    // Write-back
    // ---------------------------------------------------------------------
    assign is_imm     = op_q inside {op_ldi, op_addi, op_andi, op_ori};
    assign loads_hilo = op_q inside {op_mul, op_div};
    assign writes_reg = op_q inside {op_ldi, op_add, op_sub, op_and, op_or, op_shr, op_shra,
                                     op_shl, op_ror, op_rol, op_addi, op_andi, op_ori,
                                     op_neg, op_not, op_jal, op_mfhi, op_mflo};

    always_comb begin
        case (op_q)
            op_mfhi: result = hi_q;
            op_mflo: result = lo_q;
            op_jal:  result = pc_plus1;  // Link value.
            default: result = z_lo;
        endcase
        case (op_q)
            op_branch:     target = z_lo;
            op_jr, op_jal: target = y_q;
            default:       target = pc_plus1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
            hi_q      <= '0;
            lo_q      <= '0;
            pc_next_q <= '0;
            halted    <= 1'b0;
        end else if (done) begin
            if (wb_en) begin
                regs[rd_q] <= result;
            end
            if (loads_hilo) begin
                hi_q <= z_hi;
                lo_q <= z_lo;
            end
            pc_next_q <= target;
            if (op_q == op_halt) begin
                halted <= 1'b1;   // Sticky until reset.
            end
        end
    end

    assign busy    = (state != st_idle);
    assign done    = (state == st_wb);
    assign wb_en   = done && writes_reg && (rd_q != '0);
    assign wb_addr = rd_q;
    assign wb_data = result;
    // The new values show up in the done cycle itself.
    assign hi      = (done && loads_hilo) ? z_hi : hi_q;
    assign lo      = (done && loads_hilo) ? z_lo : lo_q;
    assign pc_next = done ? target : pc_next_q;

endmodule

//--- src/exec_top.sv
`timescale 1ns/1ns

module exec_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  exec_pkg::opcode_t            opcode,
    input  logic [exec_pkg::reg_w-1:0]   rd,
    input  logic [exec_pkg::reg_w-1:0]   ra,
    input  logic [exec_pkg::reg_w-1:0]   rb,
    input  logic [exec_pkg::data_w-1:0]  imm,
    input  logic [exec_pkg::data_w-1:0]  pc,
    input  logic                         br_flag,
    output logic                         busy,
    output logic                         done,
    output logic                         halted,
    output logic                         wb_en,
    output logic [exec_pkg::reg_w-1:0]   wb_addr,
    output logic [exec_pkg::data_w-1:0]  wb_data,
    output logic [exec_pkg::data_w-1:0]  hi,
    output logic [exec_pkg::data_w-1:0]  lo,
    output logic [exec_pkg::data_w-1:0]  pc_next
);

    alu_if u_alu_bus ();

    // ---------------------------------------------------------------------
    // Controller owns all state, the ALU is purely combinational.
    // ---------------------------------------------------------------------
    exec_ctrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .opcode  (opcode),
        .rd      (rd),
        .ra      (ra),
        .rb      (rb),
        .imm     (imm),
        .pc      (pc),
        .br_flag (br_flag),
        .alu     (u_alu_bus.ctrl),
        .busy    (busy),
        .done    (done),
        .halted  (halted),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .hi      (hi),
        .lo      (lo),
        .pc_next (pc_next)
    );

    alu u_alu (
        .bus (u_alu_bus.unit)
    );

endmodule

//--- dv/exec_assertions.sv
`timescale 1ns/1ns

module exec_assertions (
    input logic                       clk,
    input logic                       rst,
    input logic                       start,
    input logic                       busy,
    input logic                       done,
    input logic                       halted,
    input logic                       wb_en,
    input logic [exec_pkg::reg_w-1:0] wb_addr
);

    // -------------------------------------------------------------------
    // Completion timing
    // -------------------------------------------------------------------
    done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // An accepted start reaches write-back four cycles later.
    done_latency: assert property (@(posedge clk) disable iff (rst)
        start && !busy && !halted |=> !done ##1 !done ##1 !done ##1 done)
        else $error("done did not follow an accepted start by four cycles");

    wb_with_done: assert property (@(posedge clk) disable iff (rst) wb_en |-> done)
        else $error("wb_en raised outside a done cycle");

    wb_not_r0: assert property (@(posedge clk) disable iff (rst) wb_en |-> wb_addr != '0)
        else $error("write-back aimed at register 0");

    // Synchronous reset clears the sequencer by the next edge.
    quiet_in_reset: assert property (@(posedge clk) rst |=> !busy && !done)
        else $error("busy or done high during reset");

endmodule

bind exec_top exec_assertions u_assertions (.*);

//--- dv/exec_tb.sv
`timescale 1ns/1ns

module exec_tb;
    import exec_pkg::*;

    localparam int seed         = 99477;
    localparam int num_directed = 140;
    localparam int num_random   = 300;
    localparam int max_cycles   = 40 * (num_directed + num_random) + 100;

    typedef struct packed {
        logic              wb_en;
        logic [reg_w-1:0]  wb_addr;
        logic [data_w-1:0] wb_data;
        logic [data_w-1:0] hi;
        logic [data_w-1:0] lo;
        logic [data_w-1:0] pc_next;
    } expect_t;

    logic              clk, rst, start, br_flag;
    opcode_t           opcode;
    logic [reg_w-1:0]  rd, ra, rb, wb_addr;
    logic [data_w-1:0] imm, pc, wb_data, hi, lo, pc_next;
    logic              busy, done, halted, wb_en;

    logic [data_w-1:0] model_regs [num_regs];   // Shadow register file.
    logic [data_w-1:0] model_hi, model_lo;
    logic              model_halted;
    expect_t           pending [$];
    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;

    opcode_t reg_ops [9]   = '{op_add, op_sub, op_and, op_or, op_andi, op_ori, op_addi,
                               op_neg, op_not};
    opcode_t shift_ops [5] = '{op_shr, op_shra, op_shl, op_ror, op_rol};
    opcode_t quiet_ops [5] = '{op_ld, op_st, op_in, op_out, op_nop};

    exec_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // -------------------------------------------------------------------
    // Reference model
    // -------------------------------------------------------------------
    function automatic void exec_model(input opcode_t op, input logic [reg_w-1:0] rd_i, ra_i,
                                       rb_i, input logic [data_w-1:0] imm_i, pc_i,
                                       input logic br_i, output logic accepted,
                                       output expect_t want);
        logic [data_w-1:0] y, b, z_hi, z_lo, pc1, res;
        logic [shamt_w-1:0] s;
        longint            prod, quo, rem;
        want     = '0;
        accepted = !model_halted;
        if (!accepted) begin
            return;
        end
        pc1  = pc_i + 32'd1;
        y    = (op == op_branch) ? pc1 : model_regs[ra_i];
        b    = (op inside {op_ldi, op_addi, op_andi, op_ori, op_branch}) ? imm_i
                                                                         : model_regs[rb_i];
        s    = b[shamt_w-1:0];
        z_hi = '0;
        case (op)
            op_ld, op_ldi, op_st, op_add, op_addi: z_lo = y + b;
            op_sub:          z_lo = y - b;
            op_and, op_andi: z_lo = y & b;
            op_or, op_ori:   z_lo = y | b;
            op_neg:          z_lo = 32'd0 - b;
            op_not:          z_lo = ~b;
            op_shr:          z_lo = y >> s;
            op_shra:         z_lo = (y >> s) | (y[31] ? ~(32'hffff_ffff >> s) : 32'd0);
            op_shl:          z_lo = y << s;
            op_ror:          z_lo = (s == 0) ? y : ((y >> s) | (y << (6'd32 - {1'b0, s})));
            op_rol:          z_lo = (s == 0) ? y : ((y << s) | (y >> (6'd32 - {1'b0, s})));
            op_mul: begin
                prod = longint'($signed(y)) * longint'($signed(b));
                z_hi = prod[63:32];
                z_lo = prod[31:0];
            end
            op_div: begin
                if (b == '0) begin
                    z_hi = y;
                    z_lo = '0;
                end else begin
                    quo  = longint'($signed(y)) / longint'($signed(b));  // No overflow in 64 bits.
                    rem  = longint'($signed(y)) % longint'($signed(b));
                    z_hi = rem[31:0];
                    z_lo = quo[31:0];
                end
            end
            op_branch:       z_lo = br_i ? y + b : y;
            default:         z_lo = '0;
        endcase
        case (op)
            op_mfhi: res = model_hi;
            op_mflo: res = model_lo;
            op_jal:  res = pc1;
            default: res = z_lo;
        endcase
        if (op inside {op_mul, op_div}) begin
            model_hi = z_hi;
            model_lo = z_lo;
        end
        want.wb_en   = (rd_i != '0) && (op inside {op_ldi, op_add, op_sub, op_and, op_or,
                       op_shr, op_shra, op_shl, op_ror, op_rol, op_addi, op_andi, op_ori,
                       op_neg, op_not, op_jal, op_mfhi, op_mflo});
        want.wb_addr = rd_i;
        want.wb_data = res;
        want.hi      = model_hi;
        want.lo      = model_lo;
        want.pc_next = (op == op_branch) ? z_lo : (op inside {op_jr, op_jal}) ? y : pc1;
        if (want.wb_en) begin
            model_regs[rd_i] = res;
        end
        if (op == op_halt) begin
            model_halted = 1'b1;
        end
    endfunction

    task automatic check_value(input logic [data_w-1:0] actual, expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic apply_reset();
        rst   = 1'b1;
        start = 1'b0;
        repeat (3) @(posedge clk);
        #5;
        rst = 1'b0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        model_hi     = '0;
        model_lo     = '0;
        model_halted = 1'b0;
        check_value(32'(busy), 32'd0, "busy after reset");
        check_value(32'(done), 32'd0, "done after reset");
        check_value(32'(wb_en), 32'd0, "wb_en after reset");
        check_value(32'(halted), 32'd0, "halted after reset");
        check_value(hi, 32'd0, "hi after reset");
        check_value(lo, 32'd0, "lo after reset");
        check_value(pc_next, 32'd0, "pc_next after reset");
    endtask

    // Drives one instruction 5 ns after an edge and waits for its done pulse.
    task automatic issue(input opcode_t op, input logic [reg_w-1:0] rd_i, ra_i, rb_i,
                         input logic [data_w-1:0] imm_i, input logic br_i,
                         input bit poke = 1'b0);
        logic              accepted;
        expect_t           want;
        bit                seen;
        logic [data_w-1:0] pc_i;
        pc_i = $urandom();
        exec_model(op, rd_i, ra_i, rb_i, imm_i, pc_i, br_i, accepted, want);
        if (accepted) begin
            pending.push_back(want);
        end
        start   = 1'b1;
        opcode  = op;
        rd      = rd_i;
        ra      = ra_i;
        rb      = rb_i;
        imm     = imm_i;
        br_flag = br_i;
        pc      = pc_i;
        seen    = 1'b0;
        for (int i = 0; i < 4 && !seen; i++) begin
            @(posedge clk);
            #5;
            start = 1'b0;
            if (poke && i == 1) begin
                check_value(32'(busy), 32'd1, "busy while an instruction runs");
                start  = 1'b1;     // Second start lands in st_oper.
                opcode = op_ldi;
                rd     = 4'd15;
                imm    = 32'hdead_beef;
            end
            seen = done;
        end
        if (accepted && !seen) begin
            errors++;
            $display("Missing completion: %s did not finish within four cycles (time %0t)",
                     op.name(), $time);
        end
        if (seen) begin
            @(posedge clk);
            #5;
        end
    endtask

    // -------------------------------------------------------------------
    // Compare outputs in the middle of each done cycle
    // -------------------------------------------------------------------
    initial begin
        expect_t want;
        forever begin
            @(negedge clk);
            if (done === 1'b1) begin
                if (pending.size() == 0) begin
                    errors++;
                    $display("Unexpected completion at %0t with no instruction pending", $time);
                end else begin
                    want = pending.pop_front();
                    check_value(32'(wb_en), 32'(want.wb_en), "wb_en");
                    if (want.wb_en) begin
                        check_value(32'(wb_addr), 32'(want.wb_addr), "wb_addr");
                        check_value(wb_data, want.wb_data, "wb_data");
                    end
                    check_value(hi, want.hi, "hi");
                    check_value(lo, want.lo, "lo");
                    check_value(pc_next, want.pc_next, "pc_next");
                end
            end
        end
    end

    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", max_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        logic [data_w-1:0] amt;
        void'($urandom(seed));
        start   = 1'b0;
        opcode  = op_nop;
        rd      = '0;
        ra      = '0;
        rb      = '0;
        imm     = '0;
        pc      = '0;
        br_flag = 1'b0;
        apply_reset();

        issue(op_ldi, 4'd1, 4'd0, 4'd0, 32'h8000_0001, 1'b0);
        issue(op_ldi, 4'd2, 4'd0, 4'd0, 32'h0000_0005, 1'b0);
        issue(op_ldi, 4'd3, 4'd0, 4'd0, 32'hffff_fffb, 1'b0);
        issue(op_ldi, 4'd7, 4'd0, 4'd0, $urandom(), 1'b0);
        foreach (reg_ops[i]) begin
            issue(reg_ops[i], 4'd4, 4'd1, 4'd3, 32'h0f0f_1234, 1'b0);
            issue(reg_ops[i], 4'd0, 4'd2, 4'd3, 32'h0f0f_1234, 1'b0);   // R0 stays zero.
        end

        for (int k = 0; k < 5; k++) begin
            amt = (k == 0) ? 32'd0 : (k == 1) ? 32'd1 : (k == 2) ? 32'd31 : $urandom();
            issue(op_ldi, 4'd6, 4'd0, 4'd0, amt, 1'b0);
            foreach (shift_ops[i]) begin
                issue(shift_ops[i], 4'd5, 4'd1, 4'd6, 32'd0, 1'b0);
                issue(shift_ops[i], 4'd5, 4'd7, 4'd6, 32'd0, 1'b0);
            end
        end

        for (int k = 0; k < 6; k++) begin
            amt = (k == 5) ? 32'd0 : (k == 4) ? 32'hffff_fff9 : $urandom();
            issue(op_ldi, 4'd8, 4'd0, 4'd0, $urandom(), 1'b0);
            issue(op_ldi, 4'd9, 4'd0, 4'd0, amt, 1'b0);
            issue(op_mul, 4'd0, 4'd8, 4'd9, 32'd0, 1'b0);
            issue(op_mfhi, 4'd10, 4'd0, 4'd0, 32'd0, 1'b0);
            issue(op_mflo, 4'd11, 4'd0, 4'd0, 32'd0, 1'b0);
            issue(op_div, 4'd0, 4'd8, 4'd9, 32'd0, 1'b0);
            issue(op_mfhi, 4'd10, 4'd0, 4'd0, 32'd0, 1'b0);
            issue(op_mflo, 4'd11, 4'd0, 4'd0, 32'd0, 1'b0);
        end

        issue(op_branch, 4'd0, 4'd0, 4'd0, 32'h0000_0040, 1'b1);
        issue(op_branch, 4'd0, 4'd0, 4'd0, 32'hffff_fff0, 1'b1);
        issue(op_branch, 4'd0, 4'd0, 4'd0, 32'h0000_0040, 1'b0);
        issue(op_jr, 4'd0, 4'd7, 4'd0, 32'd0, 1'b0);
        issue(op_jal, 4'd12, 4'd7, 4'd0, 32'd0, 1'b0);
        issue(op_jal, 4'd7, 4'd7, 4'd0, 32'd0, 1'b0);   // Link overwrites the jump source.

        issue(op_add, 4'd13, 4'd1, 4'd2, 32'd0, 1'b0, 1'b1);
        foreach (quiet_ops[i]) begin
            issue(quiet_ops[i], 4'd14, 4'd1, 4'd2, 32'h0000_0010, 1'b0);
        end
        issue(op_halt, 4'd0, 4'd0, 4'd0, 32'd0, 1'b0);
        check_value(32'(halted), 32'd1, "halted after op_halt");
        issue(op_add, 4'd14, 4'd1, 4'd2, 32'd0, 1'b0);
        check_value(32'(halted), 32'd1, "halted holds until reset");
        apply_reset();

        repeat (num_random) begin
            issue(opcode_t'(5'($urandom_range(26))), 4'($urandom_range(15)),
                  4'($urandom_range(15)), 4'($urandom_range(15)), $urandom(),
                  1'($urandom_range(1)));
        end

        repeat (2) @(posedge clk);
        if (pending.size() != 0) begin
            errors++;
            $display("%0d instructions never completed", pending.size());
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
src/exec_pkg.sv
src/alu_if.sv
src/shift_unit.sv
src/mul_div_unit.sv
src/alu.sv
src/exec_ctrl.sv
src/exec_top.sv
dv/exec_assertions.sv
dv/exec_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= exec_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
